// File: rtl/gpu_dispatch_pkg.sv
package gpu_dispatch_pkg;

	// Defaults the top level hands down
	localparam int HW_WARPS_DEF   = 8;
	localparam int TASK_DEPTH_DEF = 256;
	localparam int REG_PAIRS_DEF  = 16;

	// Loader descriptor, 29 bits with valid on top
	typedef struct packed {
		logic       valid;
		logic [7:0] sw_warp;
		logic [8:0] pc_word;
		logic [7:0] active_mask;
		// Count of register pairs, 0 to 7
		logic [2:0] nreg_pairs;
	} task_desc_t;

	// One record seen by both fetch and SIMT
	typedef struct packed {
		logic [2:0]  hw_warp;
		logic [7:0]  sw_warp;
		logic [31:0] start_pc;
		logic [7:0]  active_mask;
		// First pair of the allocated block
		logic [3:0]  reg_base;
	} dispatch_t;

	// Warp retirement from issue
	typedef struct packed {
		logic [2:0] hw_warp;
	} exit_t;

	typedef enum logic [1:0] {
		TM_WAIT  = 2'b00,
		TM_WORK  = 2'b01,
		TM_DONE  = 2'b10,
		TM_CLEAR = 2'b11
	} tm_state_e;

endpackage

// File: rtl/task_list.sv
`timescale 1ns/1ns

module task_list #(
	parameter int TASK_DEPTH = 256
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            clear,
	input  logic                            wr_en,
	input  gpu_dispatch_pkg::task_desc_t    wr_task,
	output logic                            full,
	input  logic                            pop,
	output gpu_dispatch_pkg::task_desc_t    head,
	output logic [$clog2(TASK_DEPTH)-1:0]   head_idx,
	input  logic                            inval_en,
	input  logic [$clog2(TASK_DEPTH)-1:0]   inval_idx,
	output gpu_dispatch_pkg::task_desc_t    lookup
);

	localparam int AW = $clog2(TASK_DEPTH);

	gpu_dispatch_pkg::task_desc_t mem [TASK_DEPTH];

	// Extra top bit tells a wrapped writer from an empty list
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic        empty;

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]) && (wr_ptr[AW] != rd_ptr[AW]);

	assign head_idx = rd_ptr[AW-1:0];
	// Nothing left to hand out, so head looks invalid
	assign head     = empty ? '0 : mem[head_idx];
	// Entry of a retiring warp
	assign lookup   = mem[inval_idx];

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else if (clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_en && !full) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop && !empty) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en && !full) begin
			mem[wr_ptr[AW-1:0]] <= wr_task;
		end
		// Retire drops valid only, pair count stays
		if (inval_en) begin
			mem[inval_idx].valid <= 1'b0;
		end
	end

endmodule

// File: rtl/warp_free_fifo.sv
`timescale 1ns/1ns

module warp_free_fifo #(
	parameter int HW_WARPS = 8
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          clear,
	input  logic                          pop,
	input  logic                          push,
	input  logic [$clog2(HW_WARPS)-1:0]   push_warp,
	output logic [$clog2(HW_WARPS)-1:0]   head,
	output logic                          empty
);

	localparam int WW = $clog2(HW_WARPS);

	logic [WW-1:0] slots [HW_WARPS];
	logic [WW:0]   rd_ptr;
	logic [WW:0]   wr_ptr;

	assign empty = (rd_ptr == wr_ptr);
	assign head  = slots[rd_ptr[WW-1:0]];

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rd_ptr <= '0;
			// Every warp free, so writer sits one lap ahead
			wr_ptr <= {1'b1, {WW{1'b0}}};
			for (int i = 0; i < HW_WARPS; i++) begin
				slots[i] <= WW'(i);
			end
		end else if (clear) begin
			rd_ptr <= '0;
			wr_ptr <= {1'b1, {WW{1'b0}}};
			for (int i = 0; i < HW_WARPS; i++) begin
				slots[i] <= WW'(i);
			end
		end else begin
			if (pop && !empty) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Exited warps go to the tail
			if (push) begin
				slots[wr_ptr[WW-1:0]] <= push_warp;
				wr_ptr                <= wr_ptr + 1'b1;
			end
		end
	end

endmodule

// File: rtl/reg_alloc_unit.sv
`timescale 1ns/1ns

module reg_alloc_unit #(
	parameter int REG_PAIRS = 16,
	parameter int HW_WARPS  = 8
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           clear,
	input  logic                           alloc,
	input  logic [2:0]                     alloc_pairs,
	input  logic [$clog2(HW_WARPS)-1:0]    alloc_warp,
	input  logic                           release_en,
	input  logic [$clog2(HW_WARPS)-1:0]    release_warp,
	output logic                           fits,
	output logic [$clog2(REG_PAIRS)-1:0]   base
);

	localparam int PW = $clog2(REG_PAIRS);

	// One bit per pair, set while owned
	logic [REG_PAIRS-1:0] used;
	logic [REG_PAIRS-1:0] used_nxt;
	logic [REG_PAIRS-1:0] alloc_mask;
	logic [REG_PAIRS-1:0] rel_mask;

	// Block held by each hardware warp
	logic [PW-1:0] base_tab [HW_WARPS];
	logic [2:0]    size_tab [HW_WARPS];

	// n ones starting at bit at, anything past the top falls off
	function automatic logic [REG_PAIRS-1:0] run_mask(input logic [2:0] n, input logic [PW-1:0] at);
		logic [REG_PAIRS-1:0] m;
		m = '0;
		for (int i = 0; i < REG_PAIRS; i++) begin
			if (i < int'(n)) begin
				m[i] = 1'b1;
			end
		end
		return m << at;
	endfunction

	// First fit, walk down so the lowest start wins
	always_comb begin
		fits = 1'b0;
		base = '0;
		for (int s = REG_PAIRS - 1; s >= 0; s--) begin
			if ((s + int'(alloc_pairs) <= REG_PAIRS) &&
				((used & run_mask(alloc_pairs, PW'(s))) == '0)) begin
				fits = 1'b1;
				base = PW'(s);
			end
		end
	end

	assign alloc_mask = run_mask(alloc_pairs, base);
	assign rel_mask   = run_mask(size_tab[release_warp], base_tab[release_warp]);

	always_comb begin
		used_nxt = used;
		if (release_en) begin
			used_nxt = used_nxt & ~rel_mask;
		end
		if (alloc && fits) begin
			used_nxt = used_nxt | alloc_mask;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			used <= '0;
		end else if (clear) begin
			used <= '0;
		end else begin
			used <= used_nxt;
		end
	end

	// Remember the block so release knows what to free
	always_ff @(posedge clk) begin
		if (alloc && fits) begin
			base_tab[alloc_warp] <= base;
			size_tab[alloc_warp] <= alloc_pairs;
		end
	end

endmodule

// File: rtl/task_manager.sv
`timescale 1ns/1ns

module task_manager #(
	parameter int HW_WARPS   = 8,
	parameter int TASK_DEPTH = 256,
	parameter int REG_PAIRS  = 16
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            task_valid,
	output logic                            task_ready,
	input  gpu_dispatch_pkg::task_desc_t    task_desc,
	input  logic                            start,
	input  logic                            clear,
	input  logic                            exit_valid,
	input  gpu_dispatch_pkg::exit_t         exit,
	output logic                            dispatch_valid,
	output gpu_dispatch_pkg::dispatch_t     dispatch,
	output logic                            finished,
	// Task list side
	output logic                            tl_wr_en,
	output gpu_dispatch_pkg::task_desc_t    tl_wr_task,
	input  logic                            tl_full,
	output logic                            tl_pop,
	input  gpu_dispatch_pkg::task_desc_t    tl_head,
	input  logic [$clog2(TASK_DEPTH)-1:0]   tl_head_idx,
	output logic                            tl_inval_en,
	output logic [$clog2(TASK_DEPTH)-1:0]   tl_inval_idx,
	input  gpu_dispatch_pkg::task_desc_t    tl_lookup,
	output logic                            tl_clear,
	// Free warp FIFO side
	output logic                            ff_pop,
	output logic                            ff_push,
	output logic [$clog2(HW_WARPS)-1:0]     ff_push_warp,
	output logic                            ff_clear,
	input  logic [$clog2(HW_WARPS)-1:0]     ff_head,
	input  logic                            ff_empty,
	// Register pool side
	output logic                            ra_alloc,
	output logic [2:0]                      ra_alloc_pairs,
	output logic [$clog2(HW_WARPS)-1:0]     ra_alloc_warp,
	output logic                            ra_release,
	output logic [$clog2(HW_WARPS)-1:0]     ra_release_warp,
	output logic                            ra_clear,
	input  logic                            ra_fits,
	input  logic [$clog2(REG_PAIRS)-1:0]    ra_base
);

	localparam int WW = $clog2(HW_WARPS);
	localparam int TW = $clog2(TASK_DEPTH);

	gpu_dispatch_pkg::tm_state_e state;
	gpu_dispatch_pkg::tm_state_e state_nxt;

	logic                ready_q;
	logic                fire;
	logic                exit_ok;
	logic                work_idle;
	logic [HW_WARPS-1:0] warp_active;
	logic [WW:0]         active_cnt;
	// Hardware warp to task list slot used for invalidation
	logic [TW-1:0]       task_idx_map [HW_WARPS];

	// Low in the first cycle out of reset
	assign task_ready = ready_q && (state == gpu_dispatch_pkg::TM_WAIT) &&
		!start && !clear && !tl_full;

	// Exit has priority over a new dispatch
	assign fire = (state == gpu_dispatch_pkg::TM_WORK) && tl_head.valid && !ff_empty &&
		ra_fits && !exit_valid;
	assign exit_ok   = exit_valid && warp_active[exit.hw_warp] && tl_lookup.valid;
	assign work_idle = (state == gpu_dispatch_pkg::TM_WORK) && (active_cnt == '0) &&
		!tl_head.valid;

	// Invalid descriptors are taken and dropped
	assign tl_wr_en     = task_valid && task_ready && task_desc.valid;
	assign tl_wr_task   = task_desc;
	assign tl_pop       = fire;
	assign tl_inval_en  = exit_ok;
	assign tl_inval_idx = task_idx_map[exit.hw_warp];
	assign tl_clear     = (state == gpu_dispatch_pkg::TM_CLEAR);

	assign ff_pop       = fire;
	assign ff_push      = exit_ok;
	assign ff_push_warp = exit.hw_warp;
	assign ff_clear     = (state == gpu_dispatch_pkg::TM_CLEAR);

	assign ra_alloc        = fire;
	assign ra_alloc_pairs  = tl_head.nreg_pairs;
	assign ra_alloc_warp   = ff_head;
	assign ra_release      = exit_ok;
	assign ra_release_warp = exit.hw_warp;
	assign ra_clear        = (state == gpu_dispatch_pkg::TM_CLEAR);

	always_comb begin
		state_nxt = state;
		case (state)
			gpu_dispatch_pkg::TM_WAIT: begin
				if (clear) begin
					state_nxt = gpu_dispatch_pkg::TM_CLEAR;
				end else if (start) begin
					state_nxt = gpu_dispatch_pkg::TM_WORK;
				end
			end
			gpu_dispatch_pkg::TM_WORK: begin
				if (work_idle) begin
					state_nxt = gpu_dispatch_pkg::TM_DONE;
				end
			end
			gpu_dispatch_pkg::TM_DONE: begin
				if (clear) begin
					state_nxt = gpu_dispatch_pkg::TM_CLEAR;
				end
			end
			default: begin
				// Clear lasts one cycle
				state_nxt = gpu_dispatch_pkg::TM_WAIT;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state          <= gpu_dispatch_pkg::TM_WAIT;
			ready_q        <= 1'b0;
			dispatch_valid <= 1'b0;
			finished       <= 1'b0;
			warp_active    <= '0;
			active_cnt     <= '0;
		end else begin
			state          <= state_nxt;
			ready_q        <= (state_nxt == gpu_dispatch_pkg::TM_WAIT);
			dispatch_valid <= fire;
			// Sticky until clear
			if (work_idle) begin
				finished <= 1'b1;
			end else if (state_nxt == gpu_dispatch_pkg::TM_CLEAR) begin
				finished <= 1'b0;
			end
			if (state == gpu_dispatch_pkg::TM_CLEAR) begin
				warp_active <= '0;
				active_cnt  <= '0;
			end else if (fire) begin
				warp_active[ff_head] <= 1'b1;
				active_cnt           <= active_cnt + 1'b1;
			end else if (exit_ok) begin
				warp_active[exit.hw_warp] <= 1'b0;
				active_cnt                <= active_cnt - 1'b1;
			end
		end
	end

	// Dispatch record and slot map
	always_ff @(posedge clk) begin
		if (fire) begin
			task_idx_map[ff_head] <= tl_head_idx;
			dispatch.hw_warp      <= ff_head;
			dispatch.sw_warp      <= tl_head.sw_warp;
			// Word PC to byte address
			dispatch.start_pc     <= {21'b0, tl_head.pc_word, 2'b00};
			dispatch.active_mask  <= tl_head.active_mask;
			dispatch.reg_base     <= ra_base;
		end
	end

endmodule

// File: rtl/gpu_dispatch_top.sv
`timescale 1ns/1ns

module gpu_dispatch_top #(
	parameter int HW_WARPS   = gpu_dispatch_pkg::HW_WARPS_DEF,
	parameter int TASK_DEPTH = gpu_dispatch_pkg::TASK_DEPTH_DEF,
	parameter int REG_PAIRS  = gpu_dispatch_pkg::REG_PAIRS_DEF
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         task_valid,
	output logic                         task_ready,
	input  gpu_dispatch_pkg::task_desc_t task_desc,
	input  logic                         start,
	input  logic                         clear,
	output logic                         dispatch_valid,
	output gpu_dispatch_pkg::dispatch_t  dispatch,
	input  logic                         exit_valid,
	input  gpu_dispatch_pkg::exit_t      exit,
	output logic                         finished
);

	localparam int WW = $clog2(HW_WARPS);
	localparam int TW = $clog2(TASK_DEPTH);
	localparam int PW = $clog2(REG_PAIRS);

	// Task list
	logic                         tl_wr_en;
	gpu_dispatch_pkg::task_desc_t tl_wr_task;
	logic                         tl_full;
	logic                         tl_pop;
	gpu_dispatch_pkg::task_desc_t tl_head;
	logic [TW-1:0]                tl_head_idx;
	logic                         tl_inval_en;
	logic [TW-1:0]                tl_inval_idx;
	gpu_dispatch_pkg::task_desc_t tl_lookup;
	logic                         tl_clear;

	// Free warps
	logic          ff_pop;
	logic          ff_push;
	logic [WW-1:0] ff_push_warp;
	logic          ff_clear;
	logic [WW-1:0] ff_head;
	logic          ff_empty;

	// Register pool
	logic          ra_alloc;
	logic [2:0]    ra_alloc_pairs;
	logic [WW-1:0] ra_alloc_warp;
	logic          ra_release;
	logic [WW-1:0] ra_release_warp;
	logic          ra_clear;
	logic          ra_fits;
	logic [PW-1:0] ra_base;

	task_manager #(
		.HW_WARPS   (HW_WARPS),
		.TASK_DEPTH (TASK_DEPTH),
		.REG_PAIRS  (REG_PAIRS)
	) i_task_manager (
		.clk             (clk),
		.rst             (rst),
		.task_valid      (task_valid),
		.task_ready      (task_ready),
		.task_desc       (task_desc),
		.start           (start),
		.clear           (clear),
		.exit_valid      (exit_valid),
		.exit            (exit),
		.dispatch_valid  (dispatch_valid),
		.dispatch        (dispatch),
		.finished        (finished),
		.tl_wr_en        (tl_wr_en),
		.tl_wr_task      (tl_wr_task),
		.tl_full         (tl_full),
		.tl_pop          (tl_pop),
		.tl_head         (tl_head),
		.tl_head_idx     (tl_head_idx),
		.tl_inval_en     (tl_inval_en),
		.tl_inval_idx    (tl_inval_idx),
		.tl_lookup       (tl_lookup),
		.tl_clear        (tl_clear),
		.ff_pop          (ff_pop),
		.ff_push         (ff_push),
		.ff_push_warp    (ff_push_warp),
		.ff_clear        (ff_clear),
		.ff_head         (ff_head),
		.ff_empty        (ff_empty),
		.ra_alloc        (ra_alloc),
		.ra_alloc_pairs  (ra_alloc_pairs),
		.ra_alloc_warp   (ra_alloc_warp),
		.ra_release      (ra_release),
		.ra_release_warp (ra_release_warp),
		.ra_clear        (ra_clear),
		.ra_fits         (ra_fits),
		.ra_base         (ra_base)
	);

	task_list #(
		.TASK_DEPTH (TASK_DEPTH)
	) i_task_list (
		.clk       (clk),
		.rst       (rst),
		.clear     (tl_clear),
		.wr_en     (tl_wr_en),
		.wr_task   (tl_wr_task),
		.full      (tl_full),
		.pop       (tl_pop),
		.head      (tl_head),
		.head_idx  (tl_head_idx),
		.inval_en  (tl_inval_en),
		.inval_idx (tl_inval_idx),
		.lookup    (tl_lookup)
	);

	warp_free_fifo #(
		.HW_WARPS (HW_WARPS)
	) i_warp_free_fifo (
		.clk       (clk),
		.rst       (rst),
		.clear     (ff_clear),
		.pop       (ff_pop),
		.push      (ff_push),
		.push_warp (ff_push_warp),
		.head      (ff_head),
		.empty     (ff_empty)
	);

	reg_alloc_unit #(
		.REG_PAIRS (REG_PAIRS),
		.HW_WARPS  (HW_WARPS)
	) i_reg_alloc_unit (
		.clk          (clk),
		.rst          (rst),
		.clear        (ra_clear),
		.alloc        (ra_alloc),
		.alloc_pairs  (ra_alloc_pairs),
		.alloc_warp   (ra_alloc_warp),
		.release_en   (ra_release),
		.release_warp (ra_release_warp),
		.fits         (ra_fits),
		.base         (ra_base)
	);

endmodule

// File: test/gpu_dispatch_assertions.sv
`timescale 1ns/1ns

module gpu_dispatch_assertions #(
	parameter int HW_WARPS = 8
) (
	input logic                        clk,
	input logic                        rst,
	input gpu_dispatch_pkg::tm_state_e state,
	input logic                        dispatch_valid,
	input logic                        finished,
	input logic                        exit_valid,
	input logic [$clog2(HW_WARPS)-1:0] exit_warp,
	input logic [HW_WARPS-1:0]         warp_active
);

	// Dispatch only while working
	dispatch_in_work: assert property (@(posedge clk) disable iff (!rst)
		dispatch_valid |-> state == gpu_dispatch_pkg::TM_WORK)
		else $error("dispatch_valid outside TM_WORK");

	// Done and dispatch exclude each other
	finish_vs_dispatch: assert property (@(posedge clk) disable iff (!rst)
		!(finished && dispatch_valid))
		else $error("finished and dispatch_valid high together");

	// Only a running warp can retire
	exit_active_only: assert property (@(posedge clk) disable iff (!rst)
		exit_valid |-> warp_active[exit_warp])
		else $error("exit for a warp that is not active");

endmodule

bind task_manager gpu_dispatch_assertions #(
	.HW_WARPS (HW_WARPS)
) i_gpu_dispatch_assertions (
	.clk            (clk),
	.rst            (rst),
	.state          (state),
	.dispatch_valid (dispatch_valid),
	.finished       (finished),
	.exit_valid     (exit_valid),
	.exit_warp      (exit.hw_warp),
	.warp_active    (warp_active)
);

// File: test/tb_gpu_dispatch.sv
`timescale 1ns/1ns

module tb_gpu_dispatch;

	localparam int WAIT_LIMIT = 100;

	logic                         clk;
	logic                         rst;
	logic                         task_valid;
	logic                         task_ready;
	gpu_dispatch_pkg::task_desc_t task_desc;
	logic                         start;
	logic                         clear;
	logic                         dispatch_valid;
	gpu_dispatch_pkg::dispatch_t  dispatch;
	logic                         exit_valid;
	gpu_dispatch_pkg::exit_t      exit;
	logic                         finished;

	// Records seen on the dispatch port in arrival order
	gpu_dispatch_pkg::dispatch_t seen [$];
	string                       lines [$];
	logic                        loaded;
	logic                        running;
	logic                        fin_held;
	int                          outstanding;
	int                          errors;
	int                          checks;
	int                          tests;
	int                          tests_failed;
	int                          test_errors;

	gpu_dispatch_top i_gpu_dispatch_top (
		.clk            (clk),
		.rst            (rst),
		.task_valid     (task_valid),
		.task_ready     (task_ready),
		.task_desc      (task_desc),
		.start          (start),
		.clear          (clear),
		.dispatch_valid (dispatch_valid),
		.dispatch       (dispatch),
		.exit_valid     (exit_valid),
		.exit           (exit),
		.finished       (finished)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic report_error(input string msg);
		errors++;
		$display("ERROR at %0t ns: %s", $time, msg);
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("MISMATCH at %0t ns: %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	// Mid-cycle sampling of the outputs
	always @(negedge clk) begin
		if (rst) begin
			if (dispatch_valid) begin
				seen.push_back(dispatch);
				outstanding++;
			end
			if (running && task_ready) begin
				report_error("task_ready is high while the manager is running");
			end
			if (finished && outstanding != 0) begin
				report_error("finished is high while warps are still active");
			end
			if (fin_held && !finished) begin
				report_error("finished dropped before clear");
			end
		end
	end

	task automatic load_task(input gpu_dispatch_pkg::task_desc_t desc);
		int waited;
		waited     = 0;
		task_desc  = desc;
		task_valid = 1'b1;
		@(negedge clk);
		while (!task_ready && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (!task_ready) begin
			report_error("task load was never accepted");
		end
		// Transfer on this edge
		@(posedge clk);
		#2;
		task_valid = 1'b0;
	endtask

	task automatic pulse_start();
		start = 1'b1;
		@(posedge clk);
		#2;
		start   = 1'b0;
		running = 1'b1;
	endtask

	task automatic exit_warp(input logic [31:0] warp);
		exit_valid   = 1'b1;
		exit.hw_warp = warp[2:0];
		@(posedge clk);
		#2;
		exit_valid = 1'b0;
		outstanding--;
	endtask

	task automatic expect_dispatch(input logic [31:0] hw, input logic [31:0] sw,
		input logic [31:0] pc, input logic [31:0] mask, input logic [31:0] base);
		gpu_dispatch_pkg::dispatch_t got;
		int                          waited;
		waited = 0;
		while (seen.size() == 0 && waited < WAIT_LIMIT) begin
			@(posedge clk);
			#2;
			waited++;
		end
		if (seen.size() == 0) begin
			report_error($sformatf("no dispatch arrived for sw warp %0h", sw));
		end else begin
			got = seen.pop_front();
			check_value("dispatch.hw_warp", hw, 32'(got.hw_warp));
			check_value("dispatch.sw_warp", sw, 32'(got.sw_warp));
			check_value("dispatch.start_pc", pc, got.start_pc);
			check_value("dispatch.active_mask", mask, 32'(got.active_mask));
			check_value("dispatch.reg_base", base, 32'(got.reg_base));
		end
	endtask

	task automatic expect_finished();
		int waited;
		waited = 0;
		while (!finished && waited < WAIT_LIMIT) begin
			@(posedge clk);
			#2;
			waited++;
		end
		if (!finished) begin
			report_error("finished never rose");
		end else begin
			fin_held = 1'b1;
		end
	endtask

	task automatic clear_all();
		fin_held = 1'b0;
		clear    = 1'b1;
		@(negedge clk);
		check_value("task_ready", 32'd0, 32'(task_ready));
		@(posedge clk);
		#2;
		clear = 1'b0;
		// Manager sits in its clear state here
		@(negedge clk);
		check_value("task_ready", 32'd0, 32'(task_ready));
		check_value("finished", 32'd0, 32'(finished));
		@(posedge clk);
		#2;
		running     = 1'b0;
		outstanding = 0;
		seen.delete();
	endtask

	task automatic close_test(input logic [31:0] num);
		int bad;
		if (seen.size() != 0) begin
			report_error($sformatf("%0d dispatches nobody expected", seen.size()));
		end
		bad = errors - test_errors;
		tests++;
		if (bad != 0) begin
			tests_failed++;
		end
		$display("test %0d: %s, %0d errors", num, (bad == 0) ? "ok" : "failed", bad);
		test_errors = errors;
	endtask

	// Limit scales with the number of case lines
	initial begin
		wait (loaded === 1'b1);
		repeat (lines.size() * 50) @(posedge clk);
		$display("Watchdog expired, the cases did not complete in time");
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		string                        line;
		int                           fd;
		int                           n;
		byte                          op;
		logic [31:0]                  v [5];
		gpu_dispatch_pkg::task_desc_t desc;
		rst          = 1'b0;
		task_valid   = 1'b0;
		task_desc    = '0;
		start        = 1'b0;
		clear        = 1'b0;
		exit_valid   = 1'b0;
		exit         = '0;
		loaded       = 1'b0;
		running      = 1'b0;
		fin_held     = 1'b0;
		outstanding  = 0;
		errors       = 0;
		checks       = 0;
		tests        = 0;
		tests_failed = 0;
		test_errors  = 0;
		fd = $fopen("test/dispatch_cases.txt", "r");
		if (fd == 0) begin
			report_error("cannot open test/dispatch_cases.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				// Skip blank and comment lines
				if (n > 1 && line.getc(0) != "#") begin
					lines.push_back(line);
				end
			end
			$fclose(fd);
		end
		loaded = 1'b1;
		repeat (8) @(posedge clk);
		#2;
		rst = 1'b1;
		// All outputs low in the first cycle out of reset
		@(negedge clk);
		check_value("task_ready", 32'd0, 32'(task_ready));
		check_value("dispatch_valid", 32'd0, 32'(dispatch_valid));
		check_value("finished", 32'd0, 32'(finished));
		@(posedge clk);
		#2;
		foreach (lines[i]) begin
			op = lines[i].getc(0);
			for (int k = 0; k < 5; k++) begin
				v[k] = '0;
			end
			if (lines[i].len() > 2) begin
				n = $sscanf(lines[i].substr(2, lines[i].len() - 1), "%h %h %h %h %h",
					v[0], v[1], v[2], v[3], v[4]);
			end
			case (op)
				"L": begin
					desc.valid       = v[0][0];
					desc.sw_warp     = v[1][7:0];
					desc.pc_word     = v[2][8:0];
					desc.active_mask = v[3][7:0];
					desc.nreg_pairs  = v[4][2:0];
					load_task(desc);
				end
				"S": pulse_start();
				"E": exit_warp(v[0]);
				"X": expect_dispatch(v[0], v[1], v[2], v[3], v[4]);
				"F": expect_finished();
				"C": clear_all();
				"T": close_test(v[0]);
				default: report_error($sformatf("unknown case line %s", lines[i]));
			endcase
		end
		repeat (2) @(posedge clk);
		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests, tests_failed, checks, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// File: test/dispatch_cases.txt
# L valid sw_warp pc_word mask pairs | S | E hw_warp | C | F expect finished | T test number
# X hw_warp sw_warp start_pc mask reg_base, all values hex
L 1 10 004 ff 2
L 1 11 020 0f 3
L 0 99 033 11 1
L 1 12 1ff a5 1
S
X 0 10 00000010 ff 0
X 1 11 00000080 0f 2
X 2 12 000007fc a5 5
E 1
E 0
E 2
F
T 1
C
L 1 20 000 01 7
L 1 21 010 03 7
L 1 22 020 07 4
S
X 0 20 00000000 01 0
X 1 21 00000040 03 7
E 0
X 2 22 00000080 07 0
E 1
E 2
F
T 2
C
L 1 30 001 0f 1
L 1 31 002 0f 1
L 1 32 003 0f 1
L 1 33 004 0f 1
L 1 34 005 0f 1
L 1 35 006 0f 1
L 1 36 007 0f 1
L 1 37 008 0f 1
L 1 38 009 0f 1
L 1 39 00a 0f 1
S
X 0 30 00000004 0f 0
X 1 31 00000008 0f 1
X 2 32 0000000c 0f 2
X 3 33 00000010 0f 3
X 4 34 00000014 0f 4
X 5 35 00000018 0f 5
X 6 36 0000001c 0f 6
X 7 37 00000020 0f 7
E 5
E 2
X 5 38 00000024 0f 2
X 2 39 00000028 0f 5
E 0
E 1
E 3
E 4
E 6
E 7
E 5
E 2
F
T 3
C
L 1 40 080 3c 2
S
X 0 40 00000200 3c 0
E 0
F
T 4

// File: sources.f
rtl/gpu_dispatch_pkg.sv
rtl/task_list.sv
rtl/warp_free_fifo.sv
rtl/reg_alloc_unit.sv
rtl/task_manager.sv
rtl/gpu_dispatch_top.sv
test/gpu_dispatch_assertions.sv
test/tb_gpu_dispatch.sv

// File: run.sh
#!/bin/bash
set -e
set -o pipefail
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_gpu_dispatch \
	-f sources.f -o sim_gpu_dispatch
./obj_dir/sim_gpu_dispatch | tee sim.log
if grep -q ">>> FAIL" sim.log; then
	exit 1
fi
exit 0
